// File: verilog/cpu_isa_pkg.sv
// ********************
// cpu isa package
// opcodes, instruction field widths and the alu flag struct
// shared by the datapath, the control block and the bench
// ********************

package cpu_isa_pkg;

    // instruction byte is {opcode, operand}
    localparam int OPCODE_W  = 4;
    localparam int OPERAND_W = 4;
    localparam int INSTR_W   = OPCODE_W + OPERAND_W;

    // opcode map, high nibble of the instruction byte
    // values not listed here decode as a no-op
    typedef enum logic [OPCODE_W-1:0] {
        // a <= mem[operand]
        OP_LDA = 4'd0,
        // a <= a + mem[operand]
        OP_ADD = 4'd1,
        // a <= a - mem[operand]
        OP_SUB = 4'd2,
        // mem[operand] <= a
        OP_STA = 4'd4,
        // a <= operand, zero extended
        OP_LDI = 4'd5,
        // pc <= operand
        OP_JMP = 4'd6,
        // jump on carry
        OP_JC  = 4'd7,
        // jump on zero
        OP_JZ  = 4'd8,
        // out <= a
        OP_OUT = 4'd14,
        OP_HLT = 4'd15
    } opcode_e;

    // flags from the last add or sub
    // carry is the ninth sum bit, so after sub it means a >= b
    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

endpackage

// File: verilog/cpu_ctrl_pkg.sv
// ********************
// cpu control package
// control word layout, micro-step type and the
// encoding of the single bus driver
// ********************

package cpu_ctrl_pkg;

    // who drives the internal bus this step
    typedef enum logic [2:0] {
        // bus reads as zero
        BUS_NONE       = 3'd0,
        // pc, zero extended
        BUS_PC         = 3'd1,
        // memory at the mar
        BUS_RAM        = 3'd2,
        // low nibble of the ir, zero extended
        BUS_IR_OPERAND = 3'd3,
        BUS_ACC        = 3'd4,
        BUS_ALU        = 3'd5
    } bus_src_e;

    // micro-step within one instruction
    // every instruction walks all five steps
    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4
    } step_e;

    // all strobes active high
    // an all-zero word is a safe idle cycle
    typedef struct packed {
        // program counter
        logic     pc_inc;
        logic     pc_load;
        // memory side
        logic     mar_load;
        logic     ram_write;
        // register loads from the bus
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     out_load;
        // alu
        logic     alu_sub;
        logic     flags_load;
        // bus driver select
        bus_src_e bus_src;
    } ctrl_word_t;

endpackage

// File: verilog/control_block.sv
// ********************
// control block
// five-step sequencer, opcode decode and halt latch
// turns step and opcode into one control word per clock
// ********************

`timescale 1ns/1ps

module control_block
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  opcode_e    opcode,
    input  alu_flags_t flags,
    output ctrl_word_t ctrl,
    output logic       pc_clear,
    output logic       halted
);

    step_e step_q;
    logic  halt_q;
    logic  set_halt;

    // step counter and halt latch
    // run low puts the machine back in its reset state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q <= T0;
            halt_q <= 1'b0;
        end else if (!run) begin
            step_q <= T0;
            halt_q <= 1'b0;
        end else begin
            if (set_halt) begin
                halt_q <= 1'b1;
            end
            // frozen once halted
            if (!halt_q) begin
                case (step_q)
                    T0:      step_q <= T1;
                    T1:      step_q <= T2;
                    T2:      step_q <= T3;
                    T3:      step_q <= T4;
                    default: step_q <= T0;
                endcase
            end
        end
    end

    // microcode decode
    always_comb begin
        ctrl     = '0;
        set_halt = 1'b0;
        // idle while loading or halted
        if (run && !halt_q) begin
            case (step_q)
                // fetch address
                T0: begin
                    ctrl.bus_src  = BUS_PC;
                    ctrl.mar_load = 1'b1;
                end
                // fetch byte, bump pc
                T1: begin
                    ctrl.bus_src = BUS_RAM;
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                T2: begin
                    case (opcode)
                        // operand address into mar
                        OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                            ctrl.bus_src  = BUS_IR_OPERAND;
                            ctrl.mar_load = 1'b1;
                        end
                        OP_LDI: begin
                            ctrl.bus_src = BUS_IR_OPERAND;
                            ctrl.a_load  = 1'b1;
                        end
                        OP_OUT: begin
                            ctrl.bus_src  = BUS_ACC;
                            ctrl.out_load = 1'b1;
                        end
                        OP_JMP: begin
                            ctrl.bus_src = BUS_IR_OPERAND;
                            ctrl.pc_load = 1'b1;
                        end
                        // conditional jumps, flags gate the load
                        OP_JC: begin
                            ctrl.bus_src = BUS_IR_OPERAND;
                            ctrl.pc_load = flags.carry;
                        end
                        OP_JZ: begin
                            ctrl.bus_src = BUS_IR_OPERAND;
                            ctrl.pc_load = flags.zero;
                        end
                        OP_HLT:  set_halt = 1'b1;
                        default: ;
                    endcase
                end
                T3: begin
                    case (opcode)
                        OP_LDA: begin
                            ctrl.bus_src = BUS_RAM;
                            ctrl.a_load  = 1'b1;
                        end
                        // second operand into b
                        OP_ADD, OP_SUB: begin
                            ctrl.bus_src = BUS_RAM;
                            ctrl.b_load  = 1'b1;
                        end
                        OP_STA: begin
                            ctrl.bus_src   = BUS_ACC;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    // write back sum or difference
                    if (opcode == OP_ADD || opcode == OP_SUB) begin
                        ctrl.bus_src    = BUS_ALU;
                        ctrl.alu_sub    = (opcode == OP_SUB);
                        ctrl.a_load     = 1'b1;
                        ctrl.flags_load = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign pc_clear = !run;
    assign halted   = halt_q;

endmodule

// File: verilog/program_counter.sv
// ********************
// program counter
// 4-bit pc with clear, jump load and increment
// ********************

`timescale 1ns/1ps

module program_counter
    import cpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_clear,
    input  ctrl_word_t ctrl,
    input  logic [7:0] bus,
    output logic [3:0] pc
);

    logic [3:0] pc_q;

    // clear beats load, load beats increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= 4'd0;
        end else if (pc_clear) begin
            pc_q <= 4'd0;
        end else if (ctrl.pc_load) begin
            // jump target, low nibble only
            pc_q <= bus[3:0];
        end else if (ctrl.pc_inc) begin
            // wraps 15 to 0
            pc_q <= pc_q + 4'd1;
        end
    end

    assign pc = pc_q;

endmodule

// File: verilog/alu.sv
// ********************
// alu
// add or subtract a and b, result is combinational
// carry and zero are held until the next flags_load
// ********************

`timescale 1ns/1ps

module alu
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  logic [7:0] acc,
    input  logic [7:0] b,
    output logic [7:0] result,
    output alu_flags_t flags
);

    logic [7:0] b_operand;
    logic [8:0] sum;
    alu_flags_t flags_q;

    // two's complement sub, invert b and carry in one
    assign b_operand = ctrl.alu_sub ? ~b : b;
    assign sum       = {1'b0, acc} + {1'b0, b_operand} + {8'd0, ctrl.alu_sub};
    assign result    = sum[7:0];

    // flags only move on an add or sub write back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (ctrl.flags_load) begin
            // carry out, or no borrow after sub
            flags_q.carry <= sum[8];
            flags_q.zero  <= (sum[7:0] == 8'd0);
        end
    end

    assign flags = flags_q;

endmodule

// File: verilog/memory_unit.sv
// ********************
// memory unit
// memory address register and small register memory
// with a pin-side write port for loading programs
// ********************

`timescale 1ns/1ps

module memory_unit
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter int RAM_BYTES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  logic [OPERAND_W-1:0] load_addr,
    input  logic [7:0]           load_data,
    input  logic                 load_we,
    input  ctrl_word_t           ctrl,
    input  logic [7:0]           bus,
    output logic [7:0]           ram_data
);

    // index width, addresses use their low bits
    localparam int ADDR_W = (RAM_BYTES > 1) ? $clog2(RAM_BYTES) : 1;

    logic [OPERAND_W-1:0] mar_q;
    logic [7:0]           mem_q [RAM_BYTES];
    logic                 pin_write;
    logic [ADDR_W-1:0]    wr_index;
    logic [7:0]           wr_data;
    logic                 wr_en;

    // mar takes the low nibble of the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else if (ctrl.mar_load) begin
            mar_q <= bus[OPERAND_W-1:0];
        end
    end

    // pin port only while the machine is stopped
    assign pin_write = load_we && !run;

    // pick the single write source
    always_comb begin
        if (pin_write) begin
            wr_index = load_addr[ADDR_W-1:0];
            wr_data  = load_data;
        end else begin
            wr_index = mar_q[ADDR_W-1:0];
            wr_data  = bus;
        end
        wr_en = pin_write || ctrl.ram_write;
    end

    // memory array, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_BYTES; i++) begin
                mem_q[i] <= 8'd0;
            end
        end else if (wr_en) begin
            mem_q[wr_index] <= wr_data;
        end
    end

    // asynchronous read at the mar
    assign ram_data = mem_q[mar_q[ADDR_W-1:0]];

endmodule

// File: verilog/datapath_regs.sv
// ********************
// datapath registers
// bus multiplexer plus the ir, accumulator,
// b and output registers
// ********************

`timescale 1ns/1ps

module datapath_regs
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  logic [3:0] pc,
    input  logic [7:0] ram_data,
    input  logic [7:0] alu_result,
    output logic [7:0] bus,
    output opcode_e    opcode,
    output logic [7:0] acc,
    output logic [7:0] b,
    output logic [7:0] out_value
);

    logic [INSTR_W-1:0] ir_q;
    logic [7:0]         acc_q;
    logic [7:0]         b_q;
    logic [7:0]         out_q;

    // one driver at a time, mux instead of tri-state
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:         bus = {4'd0, pc};
            BUS_RAM:        bus = ram_data;
            // operand zero extended
            BUS_IR_OPERAND: bus = {{(8 - OPERAND_W){1'b0}}, ir_q[OPERAND_W-1:0]};
            BUS_ACC:        bus = acc_q;
            BUS_ALU:        bus = alu_result;
            default:        bus = 8'd0;
        endcase
    end

    // every register loads from the bus on its own strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_q  <= '0;
            acc_q <= 8'd0;
            b_q   <= 8'd0;
            out_q <= 8'd0;
        end else begin
            if (ctrl.ir_load) begin
                ir_q <= bus;
            end
            if (ctrl.a_load) begin
                acc_q <= bus;
            end
            if (ctrl.b_load) begin
                b_q <= bus;
            end
            // visible on the output pins
            if (ctrl.out_load) begin
                out_q <= bus;
            end
        end
    end

    // high nibble of the ir is the opcode
    assign opcode    = opcode_e'(ir_q[INSTR_W-1:OPERAND_W]);
    assign acc       = acc_q;
    assign b         = b_q;
    assign out_value = out_q;

endmodule

// File: verilog/tt_um_ece298a_8_bit_cpu_top.sv
// ********************
// 8-bit cpu top level
// tiny-chip pin map around a sap-1 style
// accumulator machine
// ********************

`timescale 1ns/1ps

module tt_um_ece298a_8_bit_cpu_top
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter int RAM_BYTES = 16
) (
    // program byte while loading
    input  logic [7:0] ui_in,
    // output register
    output logic [7:0] uo_out,
    // [7:4] load address, [2] run, [1] write strobe
    input  logic [7:0] uio_in,
    // [0] halted
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,
    // always high when powered
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    ctrl_word_t ctrl;
    alu_flags_t flags;
    opcode_e    opcode;
    logic [7:0] bus;
    logic [7:0] ram_data;
    logic [7:0] alu_result;
    logic [7:0] acc;
    logic [7:0] b;
    logic [3:0] pc;
    logic       pc_clear;
    logic       halted;
    logic       run;

    assign run = uio_in[2];

    control_block u_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .opcode   (opcode),
        .flags    (flags),
        .ctrl     (ctrl),
        .pc_clear (pc_clear),
        .halted   (halted)
    );

    program_counter u_pc (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_clear (pc_clear),
        .ctrl     (ctrl),
        .bus      (bus),
        .pc       (pc)
    );

    alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .acc    (acc),
        .b      (b),
        .result (alu_result),
        .flags  (flags)
    );

    // pins write memory only while run is low
    memory_unit #(
        .RAM_BYTES (RAM_BYTES)
    ) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_addr (uio_in[7:4]),
        .load_data (ui_in),
        .load_we   (uio_in[1]),
        .ctrl      (ctrl),
        .bus       (bus),
        .ram_data  (ram_data)
    );

    datapath_regs u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .pc         (pc),
        .ram_data   (ram_data),
        .alu_result (alu_result),
        .bus        (bus),
        .opcode     (opcode),
        .acc        (acc),
        .b          (b),
        .out_value  (uo_out)
    );

    // only bit 0 of the bidir pins is driven
    assign uio_out = {7'd0, halted};
    assign uio_oe  = 8'h01;

endmodule

// File: bench/cpu_tb_tasks.svh
// ********************
// cpu testbench tasks
// program loading, run and wait, reference model
// and the directed tests
// ********************

`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

localparam int HALT_TIMEOUT = 500;
localparam int MODEL_STEPS  = 1000;

function automatic logic [7:0] encode_instr(input opcode_e op, input logic [3:0] arg);
    return {op, arg};
endfunction

// unused bytes are no-ops whose operand is the address
task automatic fill_program();
    for (int i = 0; i < 16; i++) begin
        prog[i] = 8'hb0 | 8'(i);
    end
endtask

task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    assert (got === exp) else begin
        $display("CHECK FAILED at %0t ns: %s, got %02h expected %02h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    assert (got === exp) else begin
        $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errs_at_start);
    test_count++;
    if (error_count == errs_at_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: failed", name);
    end
endtask

// one strobed write per byte with run low
task automatic load_program();
    @(posedge clk);
    uio_in <= 8'h00;
    for (int i = 0; i < 16; i++) begin
        @(posedge clk);
        ui_in  <= prog[i];
        uio_in <= {4'(i), 4'b0010};
        @(posedge clk);
        uio_in <= {4'(i), 4'b0000};
    end
endtask

// sampled on the falling edge, away from register updates
task automatic wait_halted(input logic level, input int limit, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < limit) begin
        @(negedge clk);
        cycles++;
        ok = (uio_out[0] == level);
    end
endtask

task automatic run_until_halt();
    bit ok;
    @(posedge clk);
    uio_in <= 8'h04;
    wait_halted(1'b1, HALT_TIMEOUT, ok);
    if (!ok) begin
        $display("timeout: machine did not halt within %0d cycles, at %0t ns",
                 HALT_TIMEOUT, $time);
        error_count++;
        hung = 1'b1;
    end
endtask

// instruction level model of the isa on a copy of prog
task automatic model_predict(output logic [7:0] out_v, output bit halts);
    logic [7:0] mem [16];
    logic [7:0] instr;
    logic [7:0] a;
    logic [7:0] m;
    logic [3:0] pc;
    logic [3:0] arg;
    bit         carry;
    bit         zero;
    int         steps;
    for (int i = 0; i < 16; i++) begin
        mem[i] = prog[i];
    end
    a     = 8'd0;
    pc    = 4'd0;
    carry = 1'b0;
    zero  = 1'b0;
    out_v = 8'd0;
    halts = 1'b0;
    steps = 0;
    while (!halts && steps < MODEL_STEPS) begin
        instr = mem[pc];
        arg   = instr[3:0];
        m     = mem[arg];
        pc    = pc + 4'd1;
        case (instr[7:4])
            OP_LDA: a = m;
            OP_ADD: begin
                // carry out of the byte
                carry = ({1'b0, a} + {1'b0, m}) > 9'd255;
                a     = a + m;
                zero  = (a == 8'd0);
            end
            OP_SUB: begin
                // set when no borrow
                carry = (a >= m);
                a     = a - m;
                zero  = (a == 8'd0);
            end
            OP_STA:  mem[arg] = a;
            OP_LDI:  a = {4'd0, arg};
            OP_JMP:  pc = arg;
            OP_JC:   pc = carry ? arg : pc;
            OP_JZ:   pc = zero ? arg : pc;
            OP_OUT:  out_v = a;
            OP_HLT:  halts = 1'b1;
            default: ;
        endcase
        steps++;
    end
endtask

// a op b, out, halt
task automatic build_arith(input opcode_e op, input logic [7:0] x, input logic [7:0] y);
    fill_program();
    prog[0]  = encode_instr(OP_LDA, 4'd14);
    prog[1]  = encode_instr(op, 4'd15);
    prog[2]  = encode_instr(OP_OUT, 4'd0);
    prog[3]  = encode_instr(OP_HLT, 4'd0);
    prog[14] = x;
    prog[15] = y;
endtask

task automatic run_against_model(input string what);
    logic [7:0] exp_out;
    bit         exp_halt;
    model_predict(exp_out, exp_halt);
    load_program();
    run_until_halt();
    if (!hung) begin
        check_byte({what, " output"}, uo_out, exp_out);
        check_bit({what, " halted pin"}, uio_out[0], exp_halt);
    end
endtask

task automatic test_add_out();
    int errs;
    errs = error_count;
    // 9c + 7b wraps to 17
    build_arith(OP_ADD, 8'h9c, 8'h7b);
    load_program();
    run_until_halt();
    if (!hung) begin
        check_byte("add sum", uo_out, 8'h17);
    end
    finish_test("lda_add_out", errs);
endtask

task automatic test_sub_flags();
    int         errs;
    logic [7:0] xs [3];
    logic [7:0] ys [3];
    logic [7:0] exp_out;
    errs  = error_count;
    xs[0] = 8'h50;
    ys[0] = 8'h20;
    xs[1] = 8'h33;
    ys[1] = 8'h33;
    xs[2] = 8'h10;
    ys[2] = 8'h40;
    for (int n = 0; n < 3 && !hung; n++) begin
        fill_program();
        prog[0]  = encode_instr(OP_LDA, 4'd14);
        prog[1]  = encode_instr(OP_SUB, 4'd15);
        prog[2]  = encode_instr(OP_JZ, 4'd7);
        prog[3]  = encode_instr(OP_JC, 4'd9);
        // a below b, borrow
        prog[4]  = encode_instr(OP_LDI, 4'd3);
        prog[5]  = encode_instr(OP_OUT, 4'd0);
        prog[6]  = encode_instr(OP_HLT, 4'd0);
        prog[7]  = encode_instr(OP_LDI, 4'd2);
        prog[8]  = encode_instr(OP_JMP, 4'd5);
        prog[9]  = encode_instr(OP_LDI, 4'd1);
        prog[10] = encode_instr(OP_JMP, 4'd5);
        prog[14] = xs[n];
        prog[15] = ys[n];
        // zero wins first, then carry means a >= b
        if (xs[n] == ys[n]) begin
            exp_out = 8'd2;
        end else if (xs[n] > ys[n]) begin
            exp_out = 8'd1;
        end else begin
            exp_out = 8'd3;
        end
        load_program();
        run_until_halt();
        if (!hung) begin
            check_byte("compare branch", uo_out, exp_out);
        end
    end
    finish_test("sub_flags", errs);
endtask

task automatic test_store_reload();
    int errs;
    errs = error_count;
    fill_program();
    prog[0]  = encode_instr(OP_LDA, 4'd14);
    prog[1]  = encode_instr(OP_STA, 4'd12);
    prog[2]  = encode_instr(OP_LDI, 4'd0);
    prog[3]  = encode_instr(OP_LDA, 4'd12);
    prog[4]  = encode_instr(OP_OUT, 4'd0);
    prog[5]  = encode_instr(OP_HLT, 4'd0);
    prog[14] = 8'ha7;
    load_program();
    run_until_halt();
    if (!hung) begin
        check_byte("stored value", uo_out, 8'ha7);
    end
    finish_test("store_reload", errs);
endtask

// counts passes until f9 wraps to zero
task automatic test_loop_jumps();
    int errs;
    errs = error_count;
    fill_program();
    prog[0]  = encode_instr(OP_LDA, 4'd13);
    prog[1]  = encode_instr(OP_ADD, 4'd15);
    prog[2]  = encode_instr(OP_STA, 4'd13);
    prog[3]  = encode_instr(OP_LDA, 4'd14);
    prog[4]  = encode_instr(OP_ADD, 4'd15);
    prog[5]  = encode_instr(OP_STA, 4'd14);
    prog[6]  = encode_instr(OP_JZ, 4'd8);
    prog[7]  = encode_instr(OP_JMP, 4'd0);
    prog[8]  = encode_instr(OP_LDA, 4'd13);
    prog[9]  = encode_instr(OP_OUT, 4'd0);
    prog[10] = encode_instr(OP_HLT, 4'd0);
    prog[13] = 8'h00;
    prog[14] = 8'hf9;
    prog[15] = 8'h01;
    run_against_model("loop count");
    finish_test("loop_jumps", errs);
endtask

task automatic test_halt_reload();
    int         errs;
    logic [7:0] held;
    bit         ok;
    errs = error_count;
    // 64 - 1e
    build_arith(OP_SUB, 8'h64, 8'h1e);
    // reached only if halt fails to freeze the machine
    prog[4] = encode_instr(OP_LDI, 4'd5);
    prog[5] = encode_instr(OP_OUT, 4'd0);
    load_program();
    run_until_halt();
    if (!hung) begin
        held = uo_out;
        check_byte("sub before hold", held, 8'h46);
        // machine stays frozen
        repeat (20) begin
            @(negedge clk);
            check_byte("output while halted", uo_out, held);
            check_bit("halted held", uio_out[0], 1'b1);
        end
        @(posedge clk);
        uio_in <= 8'h00;
        wait_halted(1'b0, 4, ok);
        if (!ok) begin
            $display("timeout: halted did not clear after run went low, at %0t ns", $time);
            error_count++;
        end
        // new program from address 0, no reset
        fill_program();
        prog[0] = encode_instr(OP_LDI, 4'd9);
        prog[1] = encode_instr(OP_OUT, 4'd0);
        prog[2] = encode_instr(OP_HLT, 4'd0);
        // where a stale pc would start
        prog[4] = encode_instr(OP_LDI, 4'd5);
        prog[5] = encode_instr(OP_OUT, 4'd0);
        prog[6] = encode_instr(OP_HLT, 4'd0);
        load_program();
        run_until_halt();
    end
    if (!hung) begin
        check_byte("reloaded program", uo_out, 8'h09);
        @(posedge clk);
        rst_n  <= 1'b0;
        uio_in <= 8'h00;
        @(negedge clk);
        check_byte("output in reset", uo_out, 8'h00);
        check_bit("halted in reset", uio_out[0], 1'b0);
        check_byte("bidir enables", uio_oe, 8'h01);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end
    finish_test("halt_reload", errs);
endtask

task automatic test_random_operands();
    int         errs;
    logic [7:0] x;
    logic [7:0] y;
    errs = error_count;
    for (int n = 0; n < 8 && !hung; n++) begin
        x = 8'($random(seed));
        y = 8'($random(seed));
        build_arith(OP_ADD, x, y);
        run_against_model("random add");
        if (!hung) begin
            build_arith(OP_SUB, x, y);
            run_against_model("random sub");
        end
    end
    finish_test("random_operands", errs);
endtask

`endif

// File: bench/cpu_tb.sv
// ********************
// cpu testbench
// resets the machine, runs the directed tests
// and prints a closing summary
// ********************

`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
();

    // dut pins
    logic       clk = 1'b0;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;

    // bookkeeping
    int     error_count = 0;
    int     check_count = 0;
    int     test_count  = 0;
    int     test_idx;
    bit     hung        = 1'b0;
    integer seed        = 32'h16d5;

    // program image, loaded into the dut and read by the model
    logic [7:0] prog [16];

    // 100 MHz
    always #5 clk = ~clk;

    tt_um_ece298a_8_bit_cpu_top #(
        .RAM_BYTES (16)
    ) u_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    `include "cpu_tb_tasks.svh"

    initial begin
        ui_in  = 8'h00;
        uio_in = 8'h00;
        ena    = 1'b1;
        rst_n  = 1'b0;
        // five clocks of reset
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // a hung machine stops the sequence
        for (test_idx = 0; test_idx < 6 && !hung; test_idx++) begin
            case (test_idx)
                0:       test_add_out();
                1:       test_sub_flags();
                2:       test_store_reload();
                3:       test_loop_jumps();
                4:       test_halt_reload();
                default: test_random_operands();
            endcase
        end

        if (hung) begin
            $display("sequence stopped early after a timeout");
        end
        $display("summary: %0d tests run, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/control_block.sv
verilog/program_counter.sv
verilog/alu.sv
verilog/memory_unit.sv
verilog/datapath_regs.sv
verilog/tt_um_ece298a_8_bit_cpu_top.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the cpu testbench with verilator and run it
# exit status is nonzero when the run reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/cpu_sim

verilator --binary --timing --assert -f project.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
    echo "simulation ended without a summary"
    exit 1
fi
exit 0
